//--- logic/pgm_mem_pkg.sv
`default_nettype none

// Shared widths and types of the external memory hub
package pgm_mem_pkg;

    // DDRAM port geometry
    localparam int DDRAM_ADDR_W = 29;   // 64-bit word address
    localparam int DDRAM_DATA_W = 64;   // One beat
    localparam int DDRAM_BE_W   = 8;    // One enable per byte of the beat

    // CPU side, byte address carried as bits 23:1
    localparam int CPU_ADDR_W = 24;
    localparam int CPU_DATA_W = 16;     // Big-endian 16-bit bus

    // ROM loader side
    localparam int LOADER_ADDR_W = 27;  // Byte address from the host
    localparam int IOCTL_DATA_W  = 16;  // Host delivers 16-bit words
    localparam int IOCTL_INDEX_W = 8;

    // Main ROM download slot, other indexes are ignored here
    localparam logic [IOCTL_INDEX_W-1:0] LOADER_ROM_INDEX = 8'd0;

    // Arbiter slots
    // Same encoding is used for the sequencer state and the grant tag
    typedef enum logic [1:0] {
        client_idle  = 2'd0,    // No grant, DDRAM free for the next pick
        client_cpu   = 2'd1,    // Highest priority
        client_video = 2'd2,
        client_audio = 2'd3     // Lowest, edge triggered
    } client_t;

    // One pending loader write
    // addr is already the DDRAM word address
    // data holds the host word in all four lanes, be picks the lane
    typedef struct packed {
        logic [DDRAM_ADDR_W-1:0] addr;
        logic [DDRAM_DATA_W-1:0] data;
        logic [DDRAM_BE_W-1:0]   be;
    } loader_write_t;

    // Finished read as seen by the return stage
    typedef struct packed {
        logic    valid;     // Beat present on ddram_dout this cycle
        client_t client;    // Who the beat belongs to
    } read_done_t;

endpackage

`default_nettype wire

//--- logic/mem_request_decode.sv
`timescale 1ns/1ps
`default_nettype none

// Next-client pick and ROM loader write latch
module mem_request_decode import pgm_mem_pkg::*; (
    input  wire logic                     fixed_50m_clk,
    input  wire logic                     reset,

    input  wire logic                     ioctl_download,
    input  wire logic                     ioctl_wr,
    input  wire logic [LOADER_ADDR_W-1:0] ioctl_addr,
    input  wire logic [IOCTL_DATA_W-1:0]  ioctl_dout,
    input  wire logic [IOCTL_INDEX_W-1:0] ioctl_index,
    input  wire logic                     ddram_busy,

    input  wire logic                     cpu_req,     // Level
    input  wire logic                     vid_rd,      // Level
    input  wire logic                     sound_rd,    // Only its rising edge counts
    input  wire logic                     cpu_ack,
    input  wire logic                     vid_ack,

    output client_t                       next_client,
    output loader_write_t                 loader_wr,
    output logic                          wr_pending
);

    logic                  sound_rd_last;   // Previous sound_rd for edge detect
    logic                  sound_rise;
    logic                  wr_accept;
    logic [DDRAM_BE_W-1:0] lane_be;

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            sound_rd_last <= 1'b0;
        end else begin
            sound_rd_last <= sound_rd;
        end
    end

    assign sound_rise = sound_rd && !sound_rd_last;

    // Fixed priority, a held ack blocks its own client
    always_comb begin
        if (cpu_req && !cpu_ack) begin
            next_client = client_cpu;
        end else if (vid_rd && !vid_ack) begin
            next_client = client_video;
        end else if (sound_rise) begin
            next_client = client_audio;   // Lost if the arbiter is busy on this edge
        end else begin
            next_client = client_idle;
        end
    end

    // New ROM word only once the previous one has gone out
    assign wr_accept = ioctl_download && ioctl_wr &&
                       (ioctl_index == LOADER_ROM_INDEX) && !wr_pending;

    always_comb begin
        case (ioctl_addr[2:1])              // 16-bit lane inside the 64-bit beat
            2'd0:    lane_be = 8'h03;
            2'd1:    lane_be = 8'h0C;
            2'd2:    lane_be = 8'h30;
            default: lane_be = 8'hC0;
        endcase
    end

    always_ff @(posedge fixed_50m_clk) begin
        if (reset || !ioctl_download) begin
            wr_pending <= 1'b0;             // Dropped as soon as the download ends
        end else if (wr_accept) begin
            wr_pending <= 1'b1;
        end else if (wr_pending && !ddram_busy) begin
            wr_pending <= 1'b0;             // DDRAM took the write this cycle
        end
    end

    // Held stable while the host waits on ioctl_wait
    always_ff @(posedge fixed_50m_clk) begin
        if (wr_accept) begin
            loader_wr.addr <= {{(DDRAM_ADDR_W - LOADER_ADDR_W + 3){1'b0}},
                               ioctl_addr[LOADER_ADDR_W-1:3]};
            loader_wr.data <= {4{ioctl_dout}};
            loader_wr.be   <= lane_be;
        end
    end

endmodule

`default_nettype wire

//--- logic/ddram_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// DDRAM command sequencer
// One grant at a time, one ddram_rd pulse per grant
module ddram_sequencer import pgm_mem_pkg::*; (
    input  wire logic                    fixed_50m_clk,
    input  wire logic                    reset,

    input  wire logic                    ioctl_download,
    input  client_t                      next_client,
    input  loader_write_t                loader_wr,
    input  wire logic                    wr_pending,

    input  wire logic [CPU_ADDR_W-1:1]   cpu_addr,
    input  wire logic [DDRAM_ADDR_W-1:0] vid_addr,
    input  wire logic [DDRAM_ADDR_W-1:0] sound_addr,

    input  wire logic                    ddram_busy,
    input  wire logic                    ddram_dout_ready,

    output logic                         ddram_rd,
    output logic                         ddram_we,
    output logic [DDRAM_ADDR_W-1:0]      ddram_addr,
    output logic [DDRAM_DATA_W-1:0]      ddram_din,
    output logic [DDRAM_BE_W-1:0]        ddram_be,

    output read_done_t                   rd_done
);

    client_t state;         // Current grant, client_idle when free
    logic    rd_issued;     // Read already sent for this grant
    logic    granted;

    assign granted = (state != client_idle);

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            state     <= client_idle;
            rd_issued <= 1'b0;
        end else if (ioctl_download) begin
            // Loader owns the port, no reads at all
            state     <= client_idle;
            rd_issued <= 1'b0;
        end else begin
            case (state)
                client_idle: begin
                    rd_issued <= 1'b0;
                    // Ack of the finished read is not up yet, so no pick this cycle
                    if (!rd_done.valid) begin
                        state <= next_client;   // Stays idle when nobody asks
                    end
                end
                default: begin
                    if (ddram_rd) begin
                        rd_issued <= 1'b1;
                    end
                    if (ddram_dout_ready) begin
                        state <= client_idle;   // Beat is back, grant ends
                    end
                end
            endcase
        end
    end

    // First cycle of the grant with the port free
    assign ddram_rd = !ioctl_download && granted && !rd_issued && !ddram_busy;

    // Address mux, loader address wins during a download
    always_comb begin
        if (ioctl_download) begin
            ddram_addr = loader_wr.addr;
        end else begin
            case (state)
                client_cpu:   ddram_addr = {{(DDRAM_ADDR_W - CPU_ADDR_W + 3){1'b0}},
                                            cpu_addr[CPU_ADDR_W-1:3]};
                client_audio: ddram_addr = sound_addr;
                default:      ddram_addr = vid_addr;     // Video and idle
            endcase
        end
    end

    // Write side straight from the loader latch
    assign ddram_we  = wr_pending;
    assign ddram_din = loader_wr.data;
    assign ddram_be  = wr_pending ? loader_wr.be : {DDRAM_BE_W{1'b1}};  // Reads take the full beat

    // Completion registered on the edge that ends the ready cycle
    // Valid for one cycle, tagged with the grant that was served
    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            rd_done.valid  <= 1'b0;
            rd_done.client <= client_idle;
        end else begin
            rd_done.valid  <= ddram_dout_ready && granted && !ioctl_download;
            rd_done.client <= state;
        end
    end

endmodule

`default_nettype wire

//--- logic/read_return.sv
`timescale 1ns/1ps
`default_nettype none

// Read data capture and per-client acknowledge flags
module read_return import pgm_mem_pkg::*; (
    input  wire logic                    fixed_50m_clk,
    input  wire logic                    reset,

    input  read_done_t                   rd_done,
    input  wire logic [DDRAM_DATA_W-1:0] ddram_dout,
    input  wire logic [1:0]              cpu_lane,      // cpu_addr bits 2:1

    input  wire logic                    cpu_req,
    input  wire logic                    vid_rd,
    input  wire logic                    sound_rd,

    output logic [CPU_DATA_W-1:0]        cpu_data,
    output logic                         cpu_ack,
    output logic                         vid_ack,
    output logic                         sound_ack
);

    logic [DDRAM_DATA_W-1:0] cpu_beat;     // Last beat fetched for the CPU
    logic [CPU_DATA_W-1:0]   cpu_word;
    logic [2:0]              done_hit;     // Bit 0 CPU, 1 video, 2 audio
    logic [2:0]              req_level;
    logic [2:0]              ack_q;

    assign done_hit[0] = rd_done.valid && (rd_done.client == client_cpu);
    assign done_hit[1] = rd_done.valid && (rd_done.client == client_video);
    assign done_hit[2] = rd_done.valid && (rd_done.client == client_audio);

    assign req_level = {sound_rd, vid_rd, cpu_req};

    always_ff @(posedge fixed_50m_clk) begin
        if (done_hit[0]) begin
            cpu_beat <= ddram_dout;
        end
    end

    // Set by the beat, held until the requester lets go
    // Set wins when both happen in the same cycle
    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            ack_q <= 3'b000;
        end else begin
            ack_q <= done_hit | (ack_q & req_level);
        end
    end

    assign cpu_ack   = ack_q[0];
    assign vid_ack   = ack_q[1];
    assign sound_ack = ack_q[2];

    assign cpu_word = cpu_beat[cpu_lane*CPU_DATA_W +: CPU_DATA_W];   // Lane by address
    assign cpu_data = {cpu_word[7:0], cpu_word[15:8]};               // Swap for 68000 order

endmodule

`default_nettype wire

//--- logic/pgm_mem_hub.sv
`timescale 1ns/1ps
`default_nettype none

// External memory hub, one DDRAM port shared by loader, CPU, video and audio
module pgm_mem_hub import pgm_mem_pkg::*; (
    input  wire logic                     fixed_50m_clk,
    input  wire logic                     reset,

    // Host ROM download
    input  wire logic                     ioctl_download,
    input  wire logic                     ioctl_wr,
    input  wire logic [LOADER_ADDR_W-1:0] ioctl_addr,
    input  wire logic [IOCTL_DATA_W-1:0]  ioctl_dout,
    input  wire logic [IOCTL_INDEX_W-1:0] ioctl_index,
    output logic                          ioctl_wait,

    // CPU, video and audio read clients
    input  wire logic                     cpu_req,
    input  wire logic [CPU_ADDR_W-1:1]    cpu_addr,
    output logic                          cpu_ack,
    output logic [CPU_DATA_W-1:0]         cpu_data,
    input  wire logic                     vid_rd,
    input  wire logic [DDRAM_ADDR_W-1:0]  vid_addr,
    output logic                          vid_ack,
    input  wire logic                     sound_rd,
    input  wire logic [DDRAM_ADDR_W-1:0]  sound_addr,
    output logic                          sound_ack,

    // DDRAM port
    output logic                          ddram_rd,
    output logic                          ddram_we,
    output logic [DDRAM_ADDR_W-1:0]       ddram_addr,
    output logic [DDRAM_DATA_W-1:0]       ddram_din,
    output logic [DDRAM_BE_W-1:0]         ddram_be,
    input  wire logic [DDRAM_DATA_W-1:0]  ddram_dout,
    input  wire logic                     ddram_busy,
    input  wire logic                     ddram_dout_ready
);

    client_t       next_client;
    loader_write_t loader_wr;
    logic          wr_pending;
    read_done_t    rd_done;

    mem_request_decode mem_request_decode_inst (
        .fixed_50m_clk (fixed_50m_clk),
        .reset         (reset),
        .ioctl_download(ioctl_download),
        .ioctl_wr      (ioctl_wr),
        .ioctl_addr    (ioctl_addr),
        .ioctl_dout    (ioctl_dout),
        .ioctl_index   (ioctl_index),
        .ddram_busy    (ddram_busy),
        .cpu_req       (cpu_req),
        .vid_rd        (vid_rd),
        .sound_rd      (sound_rd),
        .cpu_ack       (cpu_ack),      // Held acks block a new grant
        .vid_ack       (vid_ack),
        .next_client   (next_client),
        .loader_wr     (loader_wr),
        .wr_pending    (wr_pending)
    );

    ddram_sequencer ddram_sequencer_inst (
        .fixed_50m_clk   (fixed_50m_clk),
        .reset           (reset),
        .ioctl_download  (ioctl_download),
        .next_client     (next_client),
        .loader_wr       (loader_wr),
        .wr_pending      (wr_pending),
        .cpu_addr        (cpu_addr),
        .vid_addr        (vid_addr),
        .sound_addr      (sound_addr),
        .ddram_busy      (ddram_busy),
        .ddram_dout_ready(ddram_dout_ready),
        .ddram_rd        (ddram_rd),
        .ddram_we        (ddram_we),
        .ddram_addr      (ddram_addr),
        .ddram_din       (ddram_din),
        .ddram_be        (ddram_be),
        .rd_done         (rd_done)
    );

    read_return read_return_inst (
        .fixed_50m_clk(fixed_50m_clk),
        .reset        (reset),
        .rd_done      (rd_done),
        .ddram_dout   (ddram_dout),
        .cpu_lane     (cpu_addr[2:1]),
        .cpu_req      (cpu_req),
        .vid_rd       (vid_rd),
        .sound_rd     (sound_rd),
        .cpu_data     (cpu_data),
        .cpu_ack      (cpu_ack),
        .vid_ack      (vid_ack),
        .sound_ack    (sound_ack)
    );

    assign ioctl_wait = wr_pending;     // Host stalls while a write is queued

endmodule

`default_nettype wire

//--- verification/pgm_mem_hub_assert.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the DDRAM command side of the sequencer
module pgm_mem_hub_assert (
    input wire logic fixed_50m_clk,
    input wire logic reset,
    input wire logic ddram_rd,
    input wire logic ddram_we,
    input wire logic ddram_busy
);

    // Read and write never share a cycle
    rd_we_exclusive: assert property (
        @(posedge fixed_50m_clk) disable iff (reset) !(ddram_rd && ddram_we)
    ) else $error("ddram_rd and ddram_we high in the same cycle");

    // A read only goes out on a free port
    rd_needs_free_port: assert property (
        @(posedge fixed_50m_clk) disable iff (reset) ddram_rd |-> !ddram_busy
    ) else $error("ddram_rd raised while ddram_busy is high");

    rd_single_cycle: assert property (
        @(posedge fixed_50m_clk) disable iff (reset) ddram_rd |=> !ddram_rd
    ) else $error("ddram_rd high on two consecutive cycles");   // One pulse per grant

endmodule

bind ddram_sequencer pgm_mem_hub_assert pgm_mem_hub_assert_inst (
    .fixed_50m_clk(fixed_50m_clk),
    .reset        (reset),
    .ddram_rd     (ddram_rd),
    .ddram_we     (ddram_we),
    .ddram_busy   (ddram_busy)
);

`default_nettype wire

//--- verification/pgm_mem_hub_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pgm_mem_hub_tb import pgm_mem_pkg::*;;

    localparam int          CLK_PERIOD     = 20;
    localparam int          TIMEOUT_CYCLES = 2000;   // All tests need a few hundred
    localparam int          WAIT_LIMIT     = 60;     // Longest wait for one level change
    localparam logic [31:0] SEED           = 32'hd37c;
    localparam int          SEL_CPU_ACK    = 0;
    localparam int          SEL_VID_ACK    = 1;
    localparam int          SEL_SOUND_ACK  = 2;

    logic                     fixed_50m_clk = 1'b0;
    logic                     reset;
    logic                     ioctl_download;
    logic                     ioctl_wr;
    logic [LOADER_ADDR_W-1:0] ioctl_addr;
    logic [IOCTL_DATA_W-1:0]  ioctl_dout;
    logic [IOCTL_INDEX_W-1:0] ioctl_index;
    logic                     ioctl_wait;
    logic                     cpu_req;
    logic [CPU_ADDR_W-1:1]    cpu_addr;
    logic                     cpu_ack;
    logic [CPU_DATA_W-1:0]    cpu_data;
    logic                     vid_rd;
    logic [DDRAM_ADDR_W-1:0]  vid_addr;
    logic                     vid_ack;
    logic                     sound_rd;
    logic [DDRAM_ADDR_W-1:0]  sound_addr;
    logic                     sound_ack;
    logic                     ddram_rd;
    logic                     ddram_we;
    logic [DDRAM_ADDR_W-1:0]  ddram_addr;
    logic [DDRAM_DATA_W-1:0]  ddram_din;
    logic [DDRAM_BE_W-1:0]    ddram_be;
    logic [DDRAM_DATA_W-1:0]  ddram_dout = '0;        // Driven by the DDRAM model
    logic                     ddram_busy;
    logic                     ddram_dout_ready = 1'b0;

    logic [DDRAM_DATA_W-1:0]  model_mem [16];         // DDRAM contents, folded by address
    logic [31:0]              stim_rng = SEED;        // Stimulus stream
    logic [31:0]              delay_rng = SEED;       // Read latency stream of the model
    int                       rd_count = 0;           // ddram_rd pulses seen so far
    int                       rd_wait = 0;
    int                       ready_cycle = 0;        // Cycle of the last ready beat
    logic [DDRAM_ADDR_W-1:0]  last_rd_addr = '0;
    int                       cycle_count = 0;

    pgm_mem_hub pgm_mem_hub_inst (.*);

    always #(CLK_PERIOD / 2) fixed_50m_clk = ~fixed_50m_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Stored word mixed with the full address
    function automatic logic [63:0] model_word(input logic [DDRAM_ADDR_W-1:0] addr);
        return model_mem[addr[3:0]] ^ {35'd0, addr};
    endfunction

    // 16-bit lane of a beat, bytes swapped for the big-endian CPU
    function automatic logic [15:0] cpu_view(input logic [63:0] beat, input int lane);
        logic [63:0] shifted;
        shifted = beat >> (16 * lane);
        return {shifted[7:0], shifted[15:8]};
    endfunction

    function automatic logic watched(input int sel);
        case (sel)
            SEL_CPU_ACK: return cpu_ack;
            SEL_VID_ACK: return vid_ack;
            SEL_SOUND_ACK: return sound_ack;
            default: return ioctl_wait;
        endcase
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
            abort_run();
        end
    endtask

    task automatic step_cycle();
        @(posedge fixed_50m_clk);
        #1;     // Inputs change just after the edge
    endtask

    // Polls at the falling edge, where everything has settled
    task automatic wait_for_level(input int sel, input logic level, input string what);
        int n;
        n = 0;
        do begin
            @(negedge fixed_50m_clk);
            n++;
        end while (watched(sel) !== level && n < WAIT_LIMIT);
        if (watched(sel) !== level) begin
            $display("%s did not go to %0b within %0d cycles", what, level, WAIT_LIMIT);
            abort_run();
        end
    endtask

    // DDRAM responder, one read in flight at most
    always begin
        @(negedge fixed_50m_clk);
        if (ddram_rd === 1'b1) begin
            if (ioctl_download) begin
                $display("ddram_rd was raised during a ROM download");
                abort_run();
            end
            check_value("ddram_be", ddram_be, 64'hFF);   // Reads take the whole beat
            rd_count = rd_count + 1;
            last_rd_addr = ddram_addr;
            delay_rng = xorshift32(delay_rng);
            rd_wait = 1 + int'(delay_rng[1:0]);    // 1 to 4 cycles
        end
        @(posedge fixed_50m_clk);
        #1;
        ddram_dout_ready = 1'b0;
        if (rd_wait > 0) begin
            rd_wait = rd_wait - 1;
            if (rd_wait == 0) begin
                ddram_dout = model_word(last_rd_addr);
                ddram_dout_ready = 1'b1;
                ready_cycle = cycle_count;
            end
        end
    end

    always @(posedge fixed_50m_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic check_reset_state();
        @(negedge fixed_50m_clk);
        check_value("ddram_rd", ddram_rd, 0);
        check_value("ddram_we", ddram_we, 0);
        check_value("ioctl_wait", ioctl_wait, 0);
        check_value("cpu_ack", cpu_ack, 0);
        check_value("vid_ack", vid_ack, 0);
        check_value("sound_ack", sound_ack, 0);
    endtask

    // One ROM word per lane, DDRAM busy for a while each time
    task automatic run_loader_writes();
        logic [LOADER_ADDR_W-1:0] addr;
        logic [IOCTL_DATA_W-1:0]  data;
        step_cycle();
        ioctl_download = 1'b1;
        ddram_busy = 1'b1;
        vid_rd = 1'b1;                          // Video asks but must be held off
        for (int lane = 0; lane < 4; lane++) begin
            stim_rng = xorshift32(stim_rng);
            addr = {stim_rng[26:3], lane[1:0], 1'b0};
            data = stim_rng[31:16];
            step_cycle();
            ioctl_addr = addr;
            ioctl_dout = data;
            ioctl_wr = 1'b1;
            step_cycle();
            ioctl_wr = 1'b0;                    // Single-cycle host strobe
            @(negedge fixed_50m_clk);
            check_value("ioctl_wait", ioctl_wait, 1);
            check_value("ddram_we", ddram_we, 1);
            check_value("ddram_addr", ddram_addr, {5'd0, addr[26:3]});
            check_value("ddram_din", ddram_din, {4{data}});
            check_value("ddram_be", ddram_be, 64'h03 << (2 * lane));
            repeat (3) begin
                @(negedge fixed_50m_clk);
                check_value("ioctl_wait", ioctl_wait, 1);
                check_value("ddram_we", ddram_we, 1);
            end
            step_cycle();
            ddram_busy = 1'b0;
            @(negedge fixed_50m_clk);
            check_value("ioctl_wait", ioctl_wait, 1);  // Clears on the coming edge
            @(negedge fixed_50m_clk);
            check_value("ioctl_wait", ioctl_wait, 0);
            check_value("ddram_we", ddram_we, 0);
            step_cycle();
            ddram_busy = 1'b1;
        end
        step_cycle();
        ioctl_download = 1'b0;
        ddram_busy = 1'b0;
        vid_rd = 1'b0;
    endtask

    task automatic run_cpu_reads();
        logic [CPU_ADDR_W-1:0]   byte_addr;
        logic [DDRAM_ADDR_W-1:0] word_addr;
        int                      start;
        for (int lane = 0; lane < 4; lane++) begin
            stim_rng = xorshift32(stim_rng);
            byte_addr = {stim_rng[23:3], lane[1:0], 1'b0};
            word_addr = {8'd0, byte_addr[23:3]};
            step_cycle();
            start = rd_count;
            cpu_addr = byte_addr[23:1];
            cpu_req = 1'b1;
            wait_for_level(SEL_CPU_ACK, 1'b1, "cpu_ack");
            // Completion one edge after the beat, ack one edge after that
            check_value("cpu_ack delay", cycle_count - ready_cycle, 2);
            check_value("cpu_data", cpu_data, cpu_view(model_word(word_addr), lane));
            step_cycle();
            check_value("ddram_rd count", rd_count, start + 1);
            check_value("ddram_addr", last_rd_addr, word_addr);
            cpu_req = 1'b0;
            wait_for_level(SEL_CPU_ACK, 1'b0, "cpu_ack");
        end
    endtask

    // CPU and video ask together, CPU goes first
    task automatic run_priority();
        logic [DDRAM_ADDR_W-1:0] cpu_word_addr;
        int                      start;
        step_cycle();
        start = rd_count;
        stim_rng = xorshift32(stim_rng);
        cpu_addr = stim_rng[23:1];
        cpu_word_addr = {8'd0, stim_rng[23:3]};
        stim_rng = xorshift32(stim_rng);
        vid_addr = stim_rng[28:0];
        cpu_req = 1'b1;
        vid_rd = 1'b1;
        wait_for_level(SEL_CPU_ACK, 1'b1, "cpu_ack");
        step_cycle();
        check_value("ddram_rd count", rd_count, start + 1);
        check_value("ddram_addr", last_rd_addr, cpu_word_addr);
        check_value("vid_ack", vid_ack, 0);
        cpu_req = 1'b0;
        wait_for_level(SEL_VID_ACK, 1'b1, "vid_ack");
        step_cycle();
        check_value("ddram_rd count", rd_count, start + 2);
        check_value("ddram_addr", last_rd_addr, vid_addr);
        vid_rd = 1'b0;
        wait_for_level(SEL_VID_ACK, 1'b0, "vid_ack");
    endtask

    task automatic run_audio_edge();
        int start;
        step_cycle();
        start = rd_count;
        stim_rng = xorshift32(stim_rng);
        sound_addr = stim_rng[28:0];
        sound_rd = 1'b1;
        wait_for_level(SEL_SOUND_ACK, 1'b1, "sound_ack");
        repeat (20) step_cycle();               // Level held, no second read expected
        check_value("ddram_rd count", rd_count, start + 1);
        check_value("ddram_addr", last_rd_addr, sound_addr);
        check_value("sound_ack", sound_ack, 1);
        sound_rd = 1'b0;
        wait_for_level(SEL_SOUND_ACK, 1'b0, "sound_ack");
    endtask

    // Video grants with busy flipping every cycle
    task automatic run_busy_grants();
        int start;
        int n;
        for (int grant = 0; grant < 2; grant++) begin
            step_cycle();
            start = rd_count;
            stim_rng = xorshift32(stim_rng);
            vid_addr = stim_rng[28:0];
            vid_rd = 1'b1;
            ddram_busy = 1'b1;
            n = 0;
            do begin
                step_cycle();
                ddram_busy = ~ddram_busy;
                @(negedge fixed_50m_clk);
                n++;
            end while (vid_ack !== 1'b1 && n < WAIT_LIMIT);
            if (vid_ack !== 1'b1) begin
                $display("vid_ack did not rise while ddram_busy was toggling");
                abort_run();
            end
            step_cycle();
            ddram_busy = 1'b0;
            check_value("ddram_rd count", rd_count, start + 1);
            check_value("ddram_addr", last_rd_addr, vid_addr);
            vid_rd = 1'b0;
            wait_for_level(SEL_VID_ACK, 1'b0, "vid_ack");
        end
    endtask

    initial begin
        reset = 1'b1;
        ioctl_download = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        ioctl_index = LOADER_ROM_INDEX;
        cpu_req = 1'b0;
        cpu_addr = '0;
        vid_rd = 1'b0;
        vid_addr = '0;
        sound_rd = 1'b0;
        sound_addr = '0;
        ddram_busy = 1'b0;
        for (int i = 0; i < 16; i++) begin
            stim_rng = xorshift32(stim_rng);
            model_mem[i][63:32] = stim_rng;
            stim_rng = xorshift32(stim_rng);
            model_mem[i][31:0] = stim_rng;
        end
        repeat (3) @(posedge fixed_50m_clk);
        #1 reset = 1'b0;
        check_reset_state();
        run_loader_writes();
        run_cpu_reads();
        run_priority();
        run_audio_edge();
        run_busy_grants();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
logic/pgm_mem_pkg.sv
logic/mem_request_decode.sv
logic/ddram_sequencer.sv
logic/read_return.sv
logic/pgm_mem_hub.sv
verification/pgm_mem_hub_assert.sv
verification/pgm_mem_hub_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= pgm_mem_hub_tb
RTL_TOP    ?= pgm_mem_hub
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
